// ==== testbench/mmio_stimulus.txt ====
# op addr data expected, all hex; one operation per clock cycle
# R read, W write, K key mask in data, P pop (data = empty flag), L lcd (data = update), I fetch
R 3FF9 0000 0000
R 3FFE 0000 0000
L 0000 0000 0000
P 0000 0001 0000
I 1234 2ABCD 2ABCD
W 0010 BEEF 0000
W 0123 5A5A 0000
W 0410 1111 0000
R 0010 0000 1111
R 0410 0000 1111
R 0123 0000 5A5A
W 03FF 7777 0000
W 3FFF 00C3 0000
L 0000 0001 00C3
L 0000 0000 00C3
R 03FF 0000 7777
R 3FFF 0000 0000
K 0000 0003 0000
K 0000 0021 0000
K 0000 003F 0000
R 3FF9 0000 0003
R 3FFA 0000 0002
R 3FFB 0000 0001
R 3FFC 0000 0001
R 3FFD 0000 0001
R 3FFE 0000 0002
W 3FFB 0000 0000
R 3FF9 0000 0003
W 3FFC 0001 0000
R 3FF9 0000 0000
R 3FFE 0000 0000
W 0000 A001 0000
W 0000 A002 0000
W 0000 A003 0000
W 0000 A004 0000
W 0000 A005 0000
W 0000 A006 0000
W 0000 A007 0000
W 0000 A008 0000
R 0000 0000 0001
W 0000 A009 0000
P 0000 0000 A001
P 0000 0000 A002
P 0000 0000 A003
P 0000 0000 A004
P 0000 0000 A005
P 0000 0000 A006
P 0000 0000 A007
P 0000 0000 A008
P 0000 0001 0000
R 0000 0000 0000

// ==== mmio.f ====
+incdir+design
design/mmio_pkg.sv
design/data_bus_if.sv
design/data_ram.sv
design/key_status.sv
design/output_devices.sv
design/mem_controller.sv
design/mmio_top.sv
testbench/mmio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f mmio.f --top-module mmio_tb -o mmio_sim

# The simulator exits nonzero on a fatal, so the log decides the result
./obj_dir/mmio_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// ==== testbench/mmio_tb.sv ====
`include "mmio_consts.svh"

`default_nettype none

module mmio_tb import mmio_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam string STIM_FILE = "testbench/mmio_stimulus.txt";

	logic                      clk;
	logic                      rst_n;
	word_t                     cpu_data_in;
	word_t                     cpu_data_addr;
	logic                      cpu_data_wr_en;
	word_t                     cpu_data_out;
	word_t                     cpu_instr_addr;
	instr_t                    main_instr_in;
	instr_t                    cpu_instr_out;
	word_t                     main_instr_addr;
	logic [`MMIO_NUM_KEYS-1:0] key_press;
	word_t                     lcd_data;
	logic                      lcd_update;
	logic                      pram_pop;
	word_t                     pram_data;
	logic                      pram_empty;

	// One entry per stimulus line
	logic [7:0]  op_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [31:0] exp_q [$];
	int          line_q [$];

	int cycles;
	int cycle_limit;

	mmio_top mmio_top_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.cpu_data_in     (cpu_data_in),
		.cpu_data_addr   (cpu_data_addr),
		.cpu_data_wr_en  (cpu_data_wr_en),
		.cpu_data_out    (cpu_data_out),
		.cpu_instr_addr  (cpu_instr_addr),
		.main_instr_in   (main_instr_in),
		.cpu_instr_out   (cpu_instr_out),
		.main_instr_addr (main_instr_addr),
		.key_press       (key_press),
		.lcd_data        (lcd_data),
		.lcd_update      (lcd_update),
		.pram_pop        (pram_pop),
		.pram_data       (pram_data),
		.pram_empty      (pram_empty)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			stop_with_failure("Value mismatch");
		end
	endtask

	// Lines starting with # are column notes
	task automatic load_stimulus();
		int          fd;
		int          code;
		int          line_no;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stop_with_failure({"Cannot open stimulus file ", STIM_FILE});
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				line_no++;
				if (code > 0 && line[0] != "#") begin
					code = $sscanf(line, "%c %h %h %h", op, a, d, e);
					if (code == 4) begin
						op_q.push_back(op);
						addr_q.push_back(a);
						data_q.push_back(d);
						exp_q.push_back(e);
						line_q.push_back(line_no);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Starts on a falling edge and returns on the next one
	task automatic apply_op(input int idx);
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		string       name;
		op   = op_q[idx];
		a    = addr_q[idx];
		d    = data_q[idx];
		e    = exp_q[idx];
		name = $sformatf("%c line %0d", op, line_q[idx]);
		cpu_data_wr_en = 1'b0;
		key_press      = '0;
		pram_pop       = 1'b0;
		case (op)
			"W": begin
				cpu_data_addr  = word_t'(a);
				cpu_data_in    = word_t'(d);
				cpu_data_wr_en = 1'b1;
			end
			"R": cpu_data_addr = word_t'(a);
			"K": key_press = d[`MMIO_NUM_KEYS-1:0];
			"P": pram_pop = 1'b1;
			"L": ;
			"I": begin
				cpu_instr_addr = word_t'(a);
				main_instr_in  = instr_t'(d);
			end
			default: stop_with_failure($sformatf("Unknown operation on stimulus line %0d",
				line_q[idx]));
		endcase
		// Just before the next rising edge
		#45;
		case (op)
			"R": check_value(name, e, 32'(cpu_data_out));
			"P": begin
				check_value({name, " empty"}, 32'(d[0]), 32'(pram_empty));
				if (!d[0]) begin
					check_value({name, " head"}, e, 32'(pram_data));
				end
			end
			"L": begin
				check_value({name, " data"}, e, 32'(lcd_data));
				check_value({name, " update"}, 32'(d[0]), 32'(lcd_update));
			end
			"I": begin
				check_value({name, " addr"}, 32'(word_t'(a)), 32'(main_instr_addr));
				check_value({name, " instr"}, e, 32'(cpu_instr_out));
			end
			default: ;
		endcase
		@(negedge clk);
	endtask

	////////////////////
	// Watchdog
	////////////////////

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		stop_with_failure($sformatf("Run did not finish within %0d cycles", cycles));
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n          = 1'b0;
		cpu_data_in    = '0;
		cpu_data_addr  = '0;
		cpu_data_wr_en = 1'b0;
		cpu_instr_addr = '0;
		main_instr_in  = '0;
		key_press      = '0;
		pram_pop       = 1'b0;
		load_stimulus();
		cycle_limit = 4 * op_q.size() + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < op_q.size(); i++) begin
			apply_op(i);
		end
		if (op_q.size() == 0) begin
			stop_with_failure("Stimulus file held no operations");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== design/mmio_top.sv ====
`include "mmio_consts.svh"

`default_nettype none

module mmio_top import mmio_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	// CPU data port
	input  word_t                     cpu_data_in,
	input  word_t                     cpu_data_addr,
	input  logic                      cpu_data_wr_en,
	output word_t                     cpu_data_out,

	// Instruction fetch, passed through
	input  word_t                     cpu_instr_addr,
	input  instr_t                    main_instr_in,
	output instr_t                    cpu_instr_out,
	output word_t                     main_instr_addr,

	// Keyboard press pulses
	input  logic [`MMIO_NUM_KEYS-1:0] key_press,

	// Output devices
	output word_t                     lcd_data,
	output logic                      lcd_update,
	input  logic                      pram_pop,
	output word_t                     pram_data,
	output logic                      pram_empty
);

	key_counts_t key_counts;
	logic        keyboard_reset;
	logic        lcd_wr_en;
	logic        pram_wr_en;
	word_t       write_data;
	logic        pram_full;

	data_bus_if ram_bus ();

	////////////////////
	// Storage
	////////////////////

	data_ram data_ram_i (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (ram_bus.memory)
	);

	key_status key_status_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.key_press      (key_press),
		.keyboard_reset (keyboard_reset),
		.key_counts     (key_counts)
	);

	output_devices output_devices_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.write_data (write_data),
		.lcd_wr_en  (lcd_wr_en),
		.pram_wr_en (pram_wr_en),
		.pram_pop   (pram_pop),
		.lcd_data   (lcd_data),
		.lcd_update (lcd_update),
		.pram_data  (pram_data),
		.pram_empty (pram_empty),
		.pram_full  (pram_full)
	);

	////////////////////
	// Decoder
	////////////////////

	mem_controller mem_controller_i (
		.cpu_data_in     (cpu_data_in),
		.cpu_data_addr   (cpu_data_addr),
		.cpu_data_wr_en  (cpu_data_wr_en),
		.cpu_instr_addr  (cpu_instr_addr),
		.main_instr_in   (main_instr_in),
		.cpu_data_out    (cpu_data_out),
		.cpu_instr_out   (cpu_instr_out),
		.main_instr_addr (main_instr_addr),
		.ram             (ram_bus.controller),
		.key_counts      (key_counts),
		.keyboard_reset  (keyboard_reset),
		.lcd_wr_en       (lcd_wr_en),
		.pram_wr_en      (pram_wr_en),
		.write_data      (write_data),
		.pram_full       (pram_full)
	);

endmodule

`default_nettype wire

// ==== design/mem_controller.sv ====
`include "mmio_consts.svh"

`default_nettype none

module mem_controller import mmio_pkg::*; (
	input  word_t       cpu_data_in,
	input  word_t       cpu_data_addr,
	input  logic        cpu_data_wr_en,
	input  word_t       cpu_instr_addr,
	input  instr_t      main_instr_in,
	output word_t       cpu_data_out,
	output instr_t      cpu_instr_out,
	output word_t       main_instr_addr,
	data_bus_if.controller ram,
	input  key_counts_t key_counts,
	output logic        keyboard_reset,
	output logic        lcd_wr_en,
	output logic        pram_wr_en,
	output word_t       write_data,
	input  logic        pram_full
);

	localparam int KEY_ID_W = $bits(key_id_e);

	logic    is_lcd;
	logic    is_pram;
	logic    is_key;
	word_t   key_offset;
	key_id_e key_sel;
	word_t   pram_status;

	////////////////////
	// Instruction port
	////////////////////

	// Instruction memory sits outside, straight through
	assign main_instr_addr = cpu_instr_addr;
	assign cpu_instr_out   = main_instr_in;

	////////////////////
	// Address decode
	////////////////////

	assign is_lcd  = (cpu_data_addr == `MMIO_ADDR_LCD);
	assign is_pram = (cpu_data_addr == `MMIO_ADDR_PRAM);

	// Addresses below the base wrap to a large offset
	assign key_offset = cpu_data_addr - `MMIO_ADDR_KEY_BASE;
	assign is_key     = (key_offset < `MMIO_NUM_KEYS);
	assign key_sel    = key_id_e'(key_offset[KEY_ID_W-1:0]);

	// Full flag in bit 0
	assign pram_status = {{(`MMIO_WORD_W - 1){1'b0}}, pram_full};

	// Same write word to every target
	assign ram.addr   = cpu_data_addr;
	assign ram.wdata  = cpu_data_in;
	assign write_data = cpu_data_in;

	////////////////////
	// Strobe steering and read mux
	////////////////////

	always_comb begin
		ram.we         = 1'b0;
		lcd_wr_en      = 1'b0;
		pram_wr_en     = 1'b0;
		keyboard_reset = 1'b0;
		cpu_data_out   = '0;

		if (is_lcd) begin
			// Write only, reads as zero
			lcd_wr_en = cpu_data_wr_en;
		end else if (is_pram) begin
			pram_wr_en   = cpu_data_wr_en;
			cpu_data_out = pram_status;
		end else if (is_key) begin
			cpu_data_out   = key_counts[key_sel];
			// Nonzero store clears all counters
			keyboard_reset = cpu_data_wr_en && (cpu_data_in != '0);
		end else begin
			ram.we       = cpu_data_wr_en;
			cpu_data_out = ram.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/output_devices.sv ====
`include "mmio_consts.svh"

`default_nettype none

module output_devices import mmio_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t write_data,
	input  logic  lcd_wr_en,
	input  logic  pram_wr_en,
	input  logic  pram_pop,
	output word_t lcd_data,
	output logic  lcd_update,
	output word_t pram_data,
	output logic  pram_empty,
	output logic  pram_full
);

	localparam int DEPTH = `PRAM_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	word_t queue [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             push;
	logic             pop;

	////////////////////
	// LCD register
	////////////////////

	// Update pulse is the cycle after the write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lcd_data   <= '0;
			lcd_update <= 1'b0;
		end else begin
			lcd_update <= lcd_wr_en;
			if (lcd_wr_en) begin
				lcd_data <= write_data;
			end
		end
	end

	////////////////////
	// PRAM queue
	////////////////////

	// Writes to a full queue are lost
	assign push = pram_wr_en && !pram_full;
	assign pop  = pram_pop && !pram_empty;

	always_comb begin
		case ({push, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk) begin
		if (push) begin
			queue[wr_ptr] <= write_data;
		end
	end

	// Flags come from the next count so they line up with it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			pram_empty <= 1'b1;
			pram_full  <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count      <= count_next;
			pram_empty <= (count_next == '0);
			pram_full  <= (count_next == CNT_W'(DEPTH));
		end
	end

	// Head entry
	assign pram_data = queue[rd_ptr];

endmodule

`default_nettype wire

// ==== design/key_status.sv ====
`include "mmio_consts.svh"

`default_nettype none

module key_status import mmio_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`MMIO_NUM_KEYS-1:0] key_press,
	input  logic                      keyboard_reset,
	output key_counts_t               key_counts
);

	key_counts_t counts_next;

	////////////////////
	// Next counts
	////////////////////

	// Each press adds one, held at the top value
	always_comb begin
		counts_next = key_counts;
		for (int k = 0; k < `MMIO_NUM_KEYS; k++) begin
			if (key_press[k] && (key_counts[k] != '1)) begin
				counts_next[k] = key_counts[k] + 1'b1;
			end
		end
	end

	////////////////////
	// Counter registers
	////////////////////

	// Clear from the CPU beats a press in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			key_counts <= '0;
		end else if (keyboard_reset) begin
			key_counts <= '0;
		end else begin
			key_counts <= counts_next;
		end
	end

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`include "mmio_consts.svh"

`default_nettype none

module data_ram import mmio_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	data_bus_if.memory bus
);

	localparam int RAM_WORDS = 2 ** `DATA_RAM_AW;

	// Contents are left as they are through reset
	word_t mem [RAM_WORDS];

	logic [`DATA_RAM_AW-1:0] index;

	// Upper address bits are ignored, so addresses alias
	assign index = bus.addr[`DATA_RAM_AW-1:0];

	////////////////////
	// Read port
	////////////////////

	assign bus.rdata = mem[index];

	////////////////////
	// Write port
	////////////////////

	// No stores land while the core is held in reset
	always_ff @(posedge clk) begin
		if (rst_n && bus.we) begin
			mem[index] <= bus.wdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/data_bus_if.sv ====
`default_nettype none

interface data_bus_if import mmio_pkg::*; ();

	// Plain strobe bus, no handshake
	word_t addr;
	word_t wdata;
	logic  we;
	word_t rdata;

	// Decoder side
	modport controller (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	// RAM side, rdata follows addr in the same cycle
	modport memory (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

`default_nettype wire

// ==== design/mmio_pkg.sv ====
`include "mmio_consts.svh"

`default_nettype none

package mmio_pkg;

	// CPU data word, also used for addresses
	typedef logic [`MMIO_WORD_W-1:0] word_t;

	typedef logic [`MMIO_INSTR_W-1:0] instr_t;

	// Numbered in address order from the key base
	typedef enum logic [$clog2(`MMIO_NUM_KEYS)-1:0] {
		reset_key  = 0,  // Esc
		shoot      = 1,  // Spacebar
		turn_left  = 2,  // A
		turn_right = 3,  // D
		backward   = 4,  // S
		forward    = 5   // W
	} key_id_e;

	// One press count per key
	typedef word_t [forward:reset_key] key_counts_t;

endpackage

`default_nettype wire

// ==== design/mmio_consts.svh ====
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

`default_nettype none

////////////////////
// Data path widths
////////////////////

`define MMIO_WORD_W         16
`define MMIO_INSTR_W        18

////////////////////
// Address map
////////////////////

// PRAM command queue, status readable at the same address
`define MMIO_ADDR_PRAM      16'h0000
`define MMIO_ADDR_LCD       16'h3FFF

// Key counters run upward from here: Esc, Spacebar, A, D, S, W
`define MMIO_ADDR_KEY_BASE  16'h3FF9
`define MMIO_NUM_KEYS       6

// Low address bits that index the data RAM
`define DATA_RAM_AW         10
`define PRAM_QUEUE_DEPTH    8

`default_nettype wire

`endif
